//--- Makefile
VERILATOR  ?= verilator
TOP        := rv_core_tb
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0 --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "=== FAIL ===" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/rv_alu.sv
`timescale 1ns/1ps

module rv_alu (
  input  rv_core_pkg::ctrl_t ctrl,
  input  logic [31:0]        rs1_data,
  input  logic [31:0]        rs2_data,
  input  logic [31:0]        imm,
  output logic [31:0]        result
);

  import rv_core_pkg::*;

  logic [31:0] a;
  logic [31:0] b;
  logic [ 4:0] shamt;

  // ----------------------------------------------------------
  // Operand selection
  // ----------------------------------------------------------
  assign a     = (ctrl.alu_a_src == A_ZERO) ? '0 : rs1_data;
  assign b     = ctrl.alu_b_imm ? imm : rs2_data;
  assign shamt = b[4:0];

  // ----------------------------------------------------------
  // Operations
  // ----------------------------------------------------------
  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  result = a + b;
      // Wraps modulo 2^32
      ALU_SUB:  result = a - b;
      ALU_AND:  result = a & b;
      ALU_OR:   result = a | b;
      ALU_XOR:  result = a ^ b;
      ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
      ALU_SLTU: result = {31'b0, a < b};
      ALU_SLL:  result = a << shamt;
      ALU_SRL:  result = a >> shamt;
      // Sign fill from bit 31
      ALU_SRA:  result = $unsigned($signed(a) >>> shamt);
      default:  result = a + b;
    endcase
  end

endmodule

//--- design/rv_core.sv
`timescale 1ns/1ps

module rv_core #(
  parameter logic [31:0] RESET_PC = 32'h0
) (
  input  logic        clk,
  input  logic        rst_n,

  // Instruction memory, read only
  output logic [31:0] imem_raddr,
  input  logic [31:0] imem_rdata,

  // Data memory
  output logic [31:0] dmem_raddr,
  input  logic [31:0] dmem_rdata,
  output logic        dmem_we,
  output logic [31:0] dmem_waddr,
  output logic [31:0] dmem_wdata,

  output logic        ebreak
);

  import rv_core_pkg::*;

  ctrl_t       ctrl;
  logic [ 4:0] rs1;
  logic [ 4:0] rs2;
  logic [ 4:0] rd;
  logic [31:0] imm;
  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] rd_data;
  logic [31:0] alu_result;
  logic [31:0] pc;
  logic [31:0] pc_plus4;

  rv_decoder decoder (
    .instr(imem_rdata),
    .ctrl (ctrl),
    .rs1  (rs1),
    .rs2  (rs2),
    .rd   (rd),
    .imm  (imm)
  );

  rv_regfile regfile (
    .clk     (clk),
    .rst_n   (rst_n),
    .rs1_addr(rs1),
    .rs2_addr(rs2),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .rd_en   (ctrl.reg_write),
    .rd_addr (rd),
    .rd_data (rd_data)
  );

  rv_alu alu (
    .ctrl    (ctrl),
    .rs1_data(rs1_data),
    .rs2_data(rs2_data),
    .imm     (imm),
    .result  (alu_result)
  );

  rv_pc_unit #(
    .RESET_PC(RESET_PC)
  ) pc_unit (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .imm       (imm),
    .alu_result(alu_result),
    .pc        (pc),
    .pc_plus4  (pc_plus4)
  );

  // ----------------------------------------------------------
  // Writeback select
  // ----------------------------------------------------------
  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = dmem_rdata;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  // Memory ports, word access only
  assign imem_raddr = pc;
  assign dmem_raddr = alu_result;
  assign dmem_waddr = alu_result;
  assign dmem_wdata = rs2_data;

  // Quiet while held in reset
  assign dmem_we = ctrl.mem_write & rst_n;
  assign ebreak  = ctrl.is_ebreak & rst_n;

endmodule

//--- design/rv_core_pkg.sv
package rv_core_pkg;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  // First ALU operand, zero is used by LUI
  typedef enum logic {
    A_RS1,
    A_ZERO
  } alu_a_src_e;

  // Writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } res_src_e;

  // ----------------------------------------------------------
  // Decoded control for one instruction
  // ----------------------------------------------------------
  typedef struct packed {
    logic       reg_write;
    logic       mem_write;
    alu_op_e    alu_op;
    alu_a_src_e alu_a_src;
    logic       alu_b_imm;
    res_src_e   res_src;
    logic       is_branch;
    logic       is_jump;
    logic       jalr;
    logic       is_ebreak;
    logic [2:0] funct3;
  } ctrl_t;

endpackage

//--- design/rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder (
  input  logic [31:0]                 instr,
  output rv_core_pkg::ctrl_t          ctrl,
  output logic [4:0]                  rs1,
  output logic [4:0]                  rs2,
  output logic [4:0]                  rd,
  output logic [rv_isa_pkg::XLEN-1:0] imm
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic [31:0] ins;
  logic        known;
  opcode_e     opcode;
  logic [2:0]  funct3;
  logic        f7_alt;

  function automatic alu_op_e alu_op_of(input logic [2:0] f3, input logic sub,
                                        input logic sra);
    case (f3)
      F3_ADD_SUB: return sub ? ALU_SUB : ALU_ADD;
      F3_SLL:     return ALU_SLL;
      F3_SLT:     return ALU_SLT;
      F3_SLTU:    return ALU_SLTU;
      F3_XOR:     return ALU_XOR;
      F3_SR:      return sra ? ALU_SRA : ALU_SRL;
      F3_OR:      return ALU_OR;
      default:    return ALU_AND;
    endcase
  endfunction

  // Anything outside the subset runs as a NOP
  always_comb begin
    case (instr[6:0])
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_LOAD, OPC_STORE,
      OPC_BRANCH, OPC_JAL, OPC_JALR: known = 1'b1;
      OPC_SYSTEM: known = (instr == I_EBREAK);
      default:    known = 1'b0;
    endcase
  end

  assign ins    = known ? instr : I_NOP;
  assign opcode = opcode_e'(ins[6:0]);
  assign funct3 = ins[F3_LSB +: 3];
  assign f7_alt = ins[F7_ALT_BIT];
  assign rd     = ins[RD_LSB +: 5];
  assign rs1    = ins[RS1_LSB +: 5];
  assign rs2    = ins[RS2_LSB +: 5];

  // ----------------------------------------------------------
  // Immediate formats, all sign-extended from bit 31
  // ----------------------------------------------------------
  always_comb begin
    case (opcode)
      OPC_STORE:  imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      OPC_BRANCH: imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
      OPC_LUI:    imm = {ins[31:12], 12'b0};
      OPC_JAL:    imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      default:    imm = {{20{ins[31]}}, ins[31:20]};
    endcase
  end

  // Control
  always_comb begin
    ctrl        = '0;
    ctrl.funct3 = funct3;
    case (opcode)
      OPC_OP: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_op_of(funct3, f7_alt, f7_alt);
      end
      OPC_OP_IMM: begin
        // No SUBI, bit 30 is part of the immediate except for SRAI
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.alu_op    = alu_op_of(funct3, 1'b0, f7_alt);
      end
      OPC_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_a_src = A_ZERO;
        ctrl.alu_b_imm = 1'b1;
      end
      OPC_LOAD: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.res_src   = RES_MEM;
      end
      OPC_STORE: begin
        ctrl.mem_write = 1'b1;
        ctrl.alu_b_imm = 1'b1;
      end
      OPC_BRANCH: ctrl.is_branch = 1'b1;
      OPC_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.res_src   = RES_PC4;
      end
      OPC_JALR: begin
        ctrl.reg_write = 1'b1;
        ctrl.is_jump   = 1'b1;
        ctrl.jalr      = 1'b1;
        ctrl.alu_b_imm = 1'b1;
        ctrl.res_src   = RES_PC4;
      end
      OPC_SYSTEM: ctrl.is_ebreak = 1'b1;
      default: ;
    endcase
  end

endmodule

//--- design/rv_isa_pkg.sv
package rv_isa_pkg;

  // Data path width
  localparam int XLEN = 32;

  // ----------------------------------------------------------
  // Major opcodes, instr[6:0]
  // ----------------------------------------------------------
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_BRANCH = 7'b1100011,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_SYSTEM = 7'b1110011
  } opcode_e;

  // ALU funct3, shared by OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SR      = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // Branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;
  localparam logic [2:0] F3_BGE = 3'b101;

  // Field positions in the instruction word
  localparam int RD_LSB     = 7;
  localparam int F3_LSB     = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  // funct7 bit 5, selects SUB and SRA/SRAI
  localparam int F7_ALT_BIT = 30;

  // Fixed instruction words
  localparam logic [31:0] I_EBREAK = 32'h0010_0073;
  localparam logic [31:0] I_NOP    = 32'h0000_0013;

endpackage

//--- design/rv_pc_unit.sv
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter logic [rv_isa_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  rv_core_pkg::ctrl_t          ctrl,
  input  logic [rv_isa_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0] imm,
  input  logic [rv_isa_pkg::XLEN-1:0] alu_result,
  output logic [rv_isa_pkg::XLEN-1:0] pc,
  output logic [rv_isa_pkg::XLEN-1:0] pc_plus4
);

  import rv_isa_pkg::*;
  import rv_core_pkg::*;

  logic            taken;
  logic [XLEN-1:0] target;
  logic [XLEN-1:0] pc_next;

  // Branch compare
  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  taken = (rs1_data == rs2_data);
      F3_BNE:  taken = (rs1_data != rs2_data);
      F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
      F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
      default: taken = 1'b0;
    endcase
  end

  // JALR target comes from rs1 + imm in the ALU, bit 0 dropped
  assign target   = ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : pc + imm;
  assign pc_plus4 = pc + XLEN'(4);
  assign pc_next  = ((ctrl.is_branch && taken) || ctrl.is_jump) ? target : pc_plus4;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // Fetch stays word aligned across every jump and branch
  a_pc_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    pc[1:0] == 2'b00);

endmodule

//--- design/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [ 4:0] rs1_addr,
  input  logic [ 4:0] rs2_addr,
  output logic [31:0] rs1_data,
  output logic [31:0] rs2_data,
  input  logic        rd_en,
  input  logic [ 4:0] rd_addr,
  input  logic [31:0] rd_data
);

  // x0 has no storage
  logic [31:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_en && rd_addr != 5'd0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

//--- project.f
design/rv_isa_pkg.sv
design/rv_core_pkg.sv
design/rv_decoder.sv
design/rv_regfile.sv
design/rv_alu.sv
design/rv_pc_unit.sv
design/rv_core.sv
verification/rv_core_tb.sv

//--- verification/rv_core_patterns.txt
# Columns: I <instruction word hex> <mnemonic>, loaded from word 0 on
# Columns: S <store address hex> <store data hex> <test name>, in program order
# Setup x1 = 5, x2 = -3, x3 = 0x100
I 00500093 addi:x1,x0,5
I FFD00113 addi:x2,x0,-3
I 10000193 addi:x3,x0,256
# Register ALU operations, each result stored through x4
I 00208233 add:x4,x1,x2
I 0041A023 sw:x4,0(x3)
I 40100233 sub:x4,x0,x1
I 0041A223 sw:x4,4(x3)
I 0020F233 and:x4,x1,x2
I 0041A423 sw:x4,8(x3)
I 0020E233 or:x4,x1,x2
I 0041A623 sw:x4,12(x3)
I 0020C233 xor:x4,x1,x2
I 0041A823 sw:x4,16(x3)
I 00112233 slt:x4,x2,x1
I 0041AA23 sw:x4,20(x3)
I 00113233 sltu:x4,x2,x1
I 0041AC23 sw:x4,24(x3)
I 00111233 sll:x4,x2,x1
I 0041AE23 sw:x4,28(x3)
I 00115233 srl:x4,x2,x1
I 0241A023 sw:x4,32(x3)
I 40115233 sra:x4,x2,x1
I 0241A223 sw:x4,36(x3)
# Immediate forms and a full constant from LUI and ADDI
I FEC08213 addi:x4,x1,-20
I 0241A423 sw:x4,40(x3)
I 40115213 srai:x4,x2,1
I 0241A623 sw:x4,44(x3)
I DEADC2B7 lui:x5,0xDEADC
I EEF28293 addi:x5,x5,-273
I 0251A823 sw:x5,48(x3)
I 0301A303 lw:x6,48(x3)
I 0261AA23 sw:x6,52(x3)
# Branches, a taken one skips a stray store of x0
I 00108463 beq:x1,x1,+8
I 0201AC23 sw:x0,56(x3)
I 00208463 beq:x1,x2,+8
I 0211AC23 sw:x1,56(x3)
I 00209463 bne:x1,x2,+8
I 0201AC23 sw:x0,56(x3)
I 00109463 bne:x1,x1,+8
I 0211AE23 sw:x1,60(x3)
I 00114463 blt:x2,x1,+8
I 0201AC23 sw:x0,56(x3)
I 0020C463 blt:x1,x2,+8
I 0411A023 sw:x1,64(x3)
I 0020D463 bge:x1,x2,+8
I 0201AC23 sw:x0,56(x3)
I 00115463 bge:x2,x1,+8
I 0411A223 sw:x1,68(x3)
# Jumps, JALR target 0xE1 lands on 0xE0
I 0080046F jal:x8,+8
I 0201AC23 sw:x0,56(x3)
I 0481A423 sw:x8,72(x3)
I 0E100513 addi:x10,x0,0xE1
I 000504E7 jalr:x9,0(x10)
I 0201AC23 sw:x0,56(x3)
I 0201AC23 sw:x0,56(x3)
I 0201AC23 sw:x0,56(x3)
I 0491A623 sw:x9,76(x3)
# x0 ignores writes, then stop
I 00700013 addi:x0,x0,7
I 0401A823 sw:x0,80(x3)
I 00100073 ebreak
# Expected stores
S 00000100 00000002 alu_reg
S 00000104 FFFFFFFB alu_reg
S 00000108 00000005 alu_reg
S 0000010C FFFFFFFD alu_reg
S 00000110 FFFFFFF8 alu_reg
S 00000114 00000001 alu_reg
S 00000118 00000000 alu_reg
S 0000011C FFFFFFA0 alu_reg
S 00000120 07FFFFFF alu_reg
S 00000124 FFFFFFFF alu_reg
S 00000128 FFFFFFF1 alu_imm
S 0000012C FFFFFFFE alu_imm
S 00000130 DEADBEEF lui_addi
S 00000134 DEADBEEF load_store
S 00000138 00000005 branch
S 0000013C 00000005 branch
S 00000140 00000005 branch
S 00000144 00000005 branch
S 00000148 000000C4 jump
S 0000014C 000000D4 jump
S 00000150 00000000 x0_write

//--- verification/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;

  localparam int MAX_CYCLES = 2000;

  logic        clk;
  logic        rst_n;
  logic [31:0] imem_raddr;
  logic [31:0] imem_rdata;
  logic [31:0] dmem_raddr;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic [31:0] dmem_waddr;
  logic [31:0] dmem_wdata;
  logic        ebreak;
  logic [31:0] reset_word;

  logic [31:0]     imem [0:255];
  logic [31:0]     dmem [0:255];
  logic [31:0]     exp_addr [0:255];
  logic [31:0]     exp_data [0:255];
  logic [8*16-1:0] exp_test [0:255];

  int n_words;
  int n_stores;
  int exp_idx;
  int errors;
  int test_errors;
  int tests_passed;
  int tests_failed;
  int cycles;

  rv_core #(
    .RESET_PC(32'h0)
  ) dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .dmem_raddr(dmem_raddr),
    .dmem_rdata(dmem_rdata),
    .dmem_we   (dmem_we),
    .dmem_waddr(dmem_waddr),
    .dmem_wdata(dmem_wdata),
    .ebreak    (ebreak)
  );

  always #50 clk = ~clk;

  // ----------------------------------------------------------
  // Memory models, word indexed
  // ----------------------------------------------------------
  // While in reset the core fetches reset_word instead of the program
  assign imem_rdata = rst_n ? imem[imem_raddr[9:2]] : reset_word;
  assign dmem_rdata = dmem[dmem_raddr[9:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_waddr[9:2]] <= dmem_wdata;
    end
  end

  // Program words and expected stores, tagged I and S
  task automatic load_patterns();
    int               fd;
    int               code;
    logic [7:0]       tag;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [8*16-1:0]  name;
    logic [8*128-1:0] line;
    fd = $fopen("verification/rv_core_patterns.txt", "r");
    if (fd == 0) begin
      $display("Cannot open verification/rv_core_patterns.txt");
      errors++;
      return;
    end
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        void'($fgets(line, fd));
      end else if (tag == "I") begin
        code = $fscanf(fd, "%h %s", d, name);
        if (code != 2) begin
          $display("Malformed program line after word %0d", n_words);
          errors++;
        end
        imem[n_words[7:0]] = d;
        n_words++;
      end else if (tag == "S") begin
        code = $fscanf(fd, "%h %h %s", a, d, name);
        if (code != 3) begin
          $display("Malformed store line after store %0d", n_stores);
          errors++;
        end
        exp_addr[n_stores[7:0]] = a;
        exp_data[n_stores[7:0]] = d;
        exp_test[n_stores[7:0]] = name;
        n_stores++;
      end else begin
        $display("Unknown tag in the patterns file");
        errors++;
        void'($fgets(line, fd));
      end
    end
    $fclose(fd);
  endtask

  task automatic report_test(input logic [8*16-1:0] name);
    if (test_errors == 0) begin
      $display("Test %0s passed", name);
      tests_passed++;
    end else begin
      $display("Test %0s failed with %0d mismatches", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // ----------------------------------------------------------
  // Store and fetch checks, sampled before the edge updates
  // ----------------------------------------------------------
  always @(posedge clk) begin
    if (rst_n && imem_raddr[1:0] != 2'b00) begin
      $display("[FAIL] %0t: fetch address %h is not word aligned", $time, imem_raddr);
      errors++;
    end
    if (dmem_we) begin
      if (exp_idx >= n_stores) begin
        $display("Unexpected store of %h to %h after the last expected store",
                 dmem_wdata, dmem_waddr);
        errors++;
      end else begin
        if (dmem_waddr !== exp_addr[exp_idx[7:0]] || dmem_wdata !== exp_data[exp_idx[7:0]]) begin
          $display("[FAIL] %0t: test %0s wrote %h to %h, expected %h to %h", $time,
                   exp_test[exp_idx[7:0]], dmem_wdata, dmem_waddr,
                   exp_data[exp_idx[7:0]], exp_addr[exp_idx[7:0]]);
          errors++;
          test_errors++;
        end
        // Last store of a test closes it
        if (exp_idx == n_stores - 1 ||
            exp_test[exp_idx[7:0] + 8'd1] != exp_test[exp_idx[7:0]]) begin
          report_test(exp_test[exp_idx[7:0]]);
        end
        exp_idx++;
      end
    end
  end

  initial begin
    $timeformat(-9, 0, " ns", 0);
    clk   = 1'b0;
    rst_n = 1'b0;
    // SW x0, 0(x0) for the first two reset cycles, EBREAK after
    reset_word <= 32'h0000_2023;
    // Opcode 0 in unused words runs as a NOP
    for (int i = 0; i < 256; i++) begin
      imem[i[7:0]] = {i[7:0], 24'h0};
      dmem[i[7:0]] = {16'hD5A0, 6'h0, i[7:0], 2'b00};
    end
    load_patterns();

    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      if (dmem_we !== 1'b0 || ebreak !== 1'b0 || imem_raddr !== 32'h0) begin
        $display("[FAIL] %0t: outputs active during reset, we %b ebreak %b addr %h",
                 $time, dmem_we, ebreak, imem_raddr);
        errors++;
        test_errors++;
      end
      if (i == 1) begin
        reset_word <= 32'h0010_0073;
      end
    end
    rst_n <= 1'b1;
    @(posedge clk);
    if (imem_raddr !== 32'h0) begin
      $display("[FAIL] %0t: first fetch from %h, expected 0", $time, imem_raddr);
      errors++;
      test_errors++;
    end
    report_test("reset");

    cycles = 1;
    while (ebreak !== 1'b1 && cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    if (ebreak !== 1'b1) begin
      $display("Timeout: ebreak was not raised within %0d cycles", MAX_CYCLES);
      errors++;
    end else if (exp_idx != n_stores) begin
      $display("EBREAK reached with %0d expected stores never written", n_stores - exp_idx);
      errors++;
    end

    $display("Tests passed %0d, tests failed %0d, errors %0d, stores checked %0d of %0d",
             tests_passed, tests_failed, errors, exp_idx, n_stores);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule
